//--- design/gamePkg.sv
`default_nettype none

package gamePkg;

    // One bit per LED and per switch
    localparam int playW = 4;

    // Show phase timer
    // Same length for the lit interval and the dark gap
    localparam int showCycles = 8;
    localparam int showW = $clog2(showCycles);

    // Per move time limit when the timed level is chosen
    localparam int timeoutCycles = 40;
    localparam int timeoutW = $clog2(timeoutCycles);

    // Last round index for each game length
    localparam int roundsShort = 7;
    localparam int roundsLong = 15;

    // Control unit states
    typedef enum logic [3:0] {
        sIdle,
        sInit,
        sShowLoad,
        sShowOn,
        sShowOff,
        sShowNext,
        sWaitPlay,
        sCheck,
        sNextPlay,
        sNextRound,
        sWon,
        sLost
    } gameState_t;

endpackage

`default_nettype wire

//--- design/seqRomPkg.sv
`default_nettype none

package seqRomPkg;

    import gamePkg::*;

    // Address of a play, also the round index
    localparam int addrW = 4;
    localparam int romDepth = 1 << addrW;

    // Fixed sequence, every word one-hot
    localparam logic [playW-1:0] playTable [0:romDepth-1] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b0010, 4'b0010, 4'b0100, 4'b0100,
        4'b1000, 4'b1000, 4'b0001, 4'b0100
    };

endpackage

`default_nettype wire

//--- design/gameCtrlIf.sv
`timescale 1ns/100ps
`default_nettype none

interface gameCtrlIf;

    // Strobes from the FSM
    logic zeraR;
    logic registraN;
    logic registraR;
    logic zeraC;
    logic contaC;
    logic zeraCR;
    logic contaCR;
    logic zeraTM;
    logic contaTM;
    logic zeraTempo;
    logic contaTempo;
    logic ativaLeds;

    // Conditions from the datapath
    logic jogadaFeita;
    logic jogadaCorreta;
    logic enderecoIgualRodada;
    logic fimJogo;
    logic fimTM;
    logic fimTempo;

    modport ctrl (
        output zeraR, registraN, registraR, zeraC, contaC, zeraCR, contaCR,
        output zeraTM, contaTM, zeraTempo, contaTempo, ativaLeds,
        input  jogadaFeita, jogadaCorreta, enderecoIgualRodada, fimJogo, fimTM, fimTempo
    );

    modport dp (
        input  zeraR, registraN, registraR, zeraC, contaC, zeraCR, contaCR,
        input  zeraTM, contaTM, zeraTempo, contaTempo, ativaLeds,
        output jogadaFeita, jogadaCorreta, enderecoIgualRodada, fimJogo, fimTM, fimTempo
    );

endinterface

`default_nettype wire

//--- design/gameDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module gameDatapath (
    input  logic                        clock,
    input  logic                        arstN,
    input  logic [gamePkg::playW-1:0]   chaves,
    input  logic                        nivelJogadas,
    input  logic                        nivelTempo,
    gameCtrlIf.dp                       bus,
    output logic [gamePkg::playW-1:0]   leds,
    output logic                        nivelTempoReg,
    output logic [seqRomPkg::addrW-1:0] dbRodada
);

    import gamePkg::*;
    import seqRomPkg::*;

    logic                nivelJogadasReg;
    logic [playW-1:0]    jogadaReg;
    logic [playW-1:0]    chavesD;
    logic [playW-1:0]    romData;
    logic [addrW-1:0]    endereco;
    logic [addrW-1:0]    rodada;
    logic [addrW-1:0]    lastRound;
    logic [showW-1:0]    showCount;
    logic [timeoutW-1:0] tempoCount;

    // Game levels, sampled once at start
    // Load wins over clear
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            nivelJogadasReg <= 1'b0;
            nivelTempoReg   <= 1'b0;
        end else if (bus.registraN) begin
            nivelJogadasReg <= nivelJogadas;
            nivelTempoReg   <= nivelTempo;
        end else if (bus.zeraR) begin
            nivelJogadasReg <= 1'b0;
            nivelTempoReg   <= 1'b0;
        end
    end

    // Switch history and press detector
    // Pulse comes one cycle after the OR of the switches leaves zero
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            chavesD         <= '0;
            bus.jogadaFeita <= 1'b0;
        end else begin
            chavesD         <= chaves;
            bus.jogadaFeita <= (|chaves) && !(|chavesD);
        end
    end

    // Player move
    // Takes the switch value seen at the rising edge of the press
    always_ff @(posedge clock) begin
        if (bus.zeraR) begin
            jogadaReg <= '0;
        end else if (bus.registraR) begin
            jogadaReg <= chavesD;
        end
    end

    // Position inside the current round
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            endereco <= '0;
        end else if (bus.zeraC) begin
            endereco <= '0;
        end else if (bus.contaC) begin
            endereco <= endereco + 1'b1;
        end
    end

    // Current round
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            rodada <= '0;
        end else if (bus.zeraCR) begin
            rodada <= '0;
        end else if (bus.contaCR) begin
            rodada <= rodada + 1'b1;
        end
    end

    // Show timer, wraps at showCycles
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            showCount <= '0;
        end else if (bus.zeraTM) begin
            showCount <= '0;
        end else if (bus.contaTM) begin
            showCount <= bus.fimTM ? '0 : showCount + 1'b1;
        end
    end

    // Timeout timer
    // Every press restarts it
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            tempoCount <= '0;
        end else if (bus.zeraTempo || bus.jogadaFeita) begin
            tempoCount <= '0;
        end else if (bus.contaTempo) begin
            tempoCount <= bus.fimTempo ? '0 : tempoCount + 1'b1;
        end
    end

    // Sequence ROM, one cycle read latency
    always_ff @(posedge clock) begin
        romData <= playTable[endereco];
    end

    // Last round depends on the latched length level
    assign lastRound = nivelJogadasReg ? addrW'(roundsLong) : addrW'(roundsShort);

    // Comparators and timer ends
    assign bus.jogadaCorreta       = (jogadaReg == romData);
    assign bus.enderecoIgualRodada = (endereco == rodada);
    assign bus.fimJogo             = (rodada == lastRound);
    assign bus.fimTM               = (showCount == showW'(showCycles - 1));
    assign bus.fimTempo            = (tempoCount == timeoutW'(timeoutCycles - 1));

    // LEDs dark unless the FSM is showing a play
    assign leds     = bus.ativaLeds ? romData : '0;
    assign dbRodada = rodada;

endmodule

`default_nettype wire

//--- design/gameControl.sv
`timescale 1ns/100ps
`default_nettype none

module gameControl (
    input  logic    clock,
    input  logic    arstN,
    input  logic    iniciar,
    input  logic    nivelTempoReg,
    gameCtrlIf.ctrl bus,
    output logic    pronto,
    output logic    ganhou,
    output logic    perdeu,
    output logic    timeout
);

    import gamePkg::*;

    gameState_t state;
    gameState_t nextState;

    // State register
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    // Next state and strobes
    always_comb begin
        nextState      = state;
        bus.zeraR      = 1'b0;
        bus.registraN  = 1'b0;
        bus.registraR  = 1'b0;
        bus.zeraC      = 1'b0;
        bus.contaC     = 1'b0;
        bus.zeraCR     = 1'b0;
        bus.contaCR    = 1'b0;
        bus.zeraTM     = 1'b0;
        bus.contaTM    = 1'b0;
        bus.zeraTempo  = 1'b0;
        bus.contaTempo = 1'b0;
        bus.ativaLeds  = 1'b0;

        case (state)
            sIdle, sWon, sLost: begin
                if (iniciar) begin
                    nextState = sInit;
                end
            end
            sInit: begin
                // Fresh game, latch levels
                bus.zeraR     = 1'b1;
                bus.registraN = 1'b1;
                bus.zeraC     = 1'b1;
                bus.zeraCR    = 1'b1;
                bus.zeraTM    = 1'b1;
                bus.zeraTempo = 1'b1;
                nextState     = sShowLoad;
            end
            sShowLoad: begin
                // ROM read in flight
                bus.zeraTM = 1'b1;
                nextState  = sShowOn;
            end
            sShowOn: begin
                bus.ativaLeds = 1'b1;
                bus.contaTM   = 1'b1;
                if (bus.fimTM) begin
                    nextState = sShowOff;
                end
            end
            sShowOff: begin
                bus.contaTM = 1'b1;
                if (bus.fimTM) begin
                    nextState = sShowNext;
                end
            end
            sShowNext: begin
                // Whole round shown, hand over to the player
                if (bus.enderecoIgualRodada) begin
                    bus.zeraC     = 1'b1;
                    bus.zeraTempo = 1'b1;
                    nextState     = sWaitPlay;
                end else begin
                    bus.contaC = 1'b1;
                    nextState  = sShowLoad;
                end
            end
            sWaitPlay: begin
                bus.contaTempo = nivelTempoReg;
                // A press beats a timeout in the same cycle
                if (bus.jogadaFeita) begin
                    bus.registraR = 1'b1;
                    nextState     = sCheck;
                end else if (nivelTempoReg && bus.fimTempo) begin
                    nextState = sLost;
                end
            end
            sCheck: begin
                if (!bus.jogadaCorreta) begin
                    nextState = sLost;
                end else if (!bus.enderecoIgualRodada) begin
                    nextState = sNextPlay;
                end else if (bus.fimJogo) begin
                    nextState = sWon;
                end else begin
                    nextState = sNextRound;
                end
            end
            sNextPlay: begin
                bus.contaC = 1'b1;
                nextState  = sWaitPlay;
            end
            sNextRound: begin
                // One more play, replay from the first
                bus.contaCR = 1'b1;
                bus.zeraC   = 1'b1;
                bus.zeraTM  = 1'b1;
                nextState   = sShowLoad;
            end
            default: begin
                nextState = sIdle;
            end
        endcase
    end

    // Timer loss flag
    // Set on the edge into sLost, cleared when a new game starts
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            timeout <= 1'b0;
        end else if (nextState == sInit) begin
            timeout <= 1'b0;
        end else if (state == sWaitPlay && nextState == sLost) begin
            timeout <= 1'b1;
        end
    end

    // Ready while no game is running
    assign pronto = (state == sIdle) || (state == sWon) || (state == sLost);
    assign ganhou = (state == sWon);
    assign perdeu = (state == sLost);

endmodule

`default_nettype wire

//--- design/memoryGameTop.sv
`timescale 1ns/100ps
`default_nettype none

module memoryGameTop (
    input  logic                        clock,
    input  logic                        arstN,
    input  logic                        iniciar,
    input  logic [gamePkg::playW-1:0]   chaves,
    input  logic                        nivelJogadas,
    input  logic                        nivelTempo,
    output logic [gamePkg::playW-1:0]   leds,
    output logic                        pronto,
    output logic                        ganhou,
    output logic                        perdeu,
    output logic                        timeout,
    output logic [seqRomPkg::addrW-1:0] dbRodada
);

    // Timed level back to the FSM
    logic nivelTempoReg;

    // Control and status between FSM and datapath
    gameCtrlIf bus ();

    gameControl control (
        .clock         ( clock         ),
        .arstN         ( arstN         ),
        .iniciar       ( iniciar       ),
        .nivelTempoReg ( nivelTempoReg ),
        .bus           ( bus.ctrl      ),
        .pronto        ( pronto        ),
        .ganhou        ( ganhou        ),
        .perdeu        ( perdeu        ),
        .timeout       ( timeout       )
    );

    gameDatapath datapath (
        .clock         ( clock         ),
        .arstN         ( arstN         ),
        .chaves        ( chaves        ),
        .nivelJogadas  ( nivelJogadas  ),
        .nivelTempo    ( nivelTempo    ),
        .bus           ( bus.dp        ),
        .leds          ( leds          ),
        .nivelTempoReg ( nivelTempoReg ),
        .dbRodada      ( dbRodada      )
    );

endmodule

`default_nettype wire

//--- verif/memoryGame_sva.sv
`timescale 1ns/100ps
`default_nettype none

module memoryGameSva (
    input logic                      clock,
    input logic                      arstN,
    input logic                      jogadaFeita,
    input logic                      ativaLeds,
    input logic [gamePkg::playW-1:0] leds,
    input logic                      ganhou,
    input logic                      perdeu,
    input logic                      timeout
);

    // Outcome levels never overlap
    outcomeExclusive: assert property (
        @(posedge clock) disable iff (!arstN) !(ganhou && perdeu)
    ) else $error("ganhou and perdeu high together");

    // Press detector gives one cycle per press
    pressPulse: assert property (
        @(posedge clock) disable iff (!arstN) jogadaFeita |=> !jogadaFeita
    ) else $error("jogadaFeita longer than one cycle");

    // Timer loss is a kind of loss
    timeoutLost: assert property (
        @(posedge clock) disable iff (!arstN) timeout |-> perdeu
    ) else $error("timeout high without perdeu");

    // Dark outside the lit interval and a single LED inside it
    ledsDark: assert property (
        @(posedge clock) disable iff (!arstN) (ativaLeds ? $onehot(leds) : (leds == '0))
    ) else $error("leds not dark while ativaLeds low or not one-hot while high");

endmodule

// Top level sees both the interface and the LED outputs
bind memoryGameTop memoryGameSva sva (
    .clock       ( clock           ),
    .arstN       ( arstN           ),
    .jogadaFeita ( bus.jogadaFeita ),
    .ativaLeds   ( bus.ativaLeds   ),
    .leds        ( leds            ),
    .ganhou      ( ganhou          ),
    .perdeu      ( perdeu          ),
    .timeout     ( timeout         )
);

`default_nettype wire

//--- verif/memoryGameTb.sv
`timescale 1ns/100ps
`default_nettype none

module memoryGameTb;

    import gamePkg::*;
    import seqRomPkg::*;

    localparam int clkPeriod = 4;
    // Worst case per round is every play lit and dark plus a full timeout per move
    localparam int roundCycles = (roundsLong + 1) * (2 * showCycles + 2 + timeoutCycles);
    localparam int gameCycles = (roundsLong + 1) * roundCycles;
    localparam int numGames = 5;
    // Longer than one timeout period
    localparam int idleCycles = timeoutCycles + 10;

    logic               clock;
    logic               arstN;
    logic               iniciar;
    logic [playW-1:0]   chaves;
    logic               nivelJogadas;
    logic               nivelTempo;
    logic [playW-1:0]   leds;
    logic               pronto;
    logic               ganhou;
    logic               perdeu;
    logic               timeout;
    logic [addrW-1:0]   dbRodada;

    logic [31:0]        seed = 32'he2aa_ed4d;
    int                 errorCount = 0;
    int                 checkCount = 0;
    // Plays lit so far in the current round
    int                 shownCount = 0;
    logic [playW-1:0]   ledsD;
    logic [addrW-1:0]   rodadaD;

    memoryGameTop uut (
        .clock        ( clock        ),
        .arstN        ( arstN        ),
        .iniciar      ( iniciar      ),
        .chaves       ( chaves       ),
        .nivelJogadas ( nivelJogadas ),
        .nivelTempo   ( nivelTempo   ),
        .leds         ( leds         ),
        .pronto       ( pronto       ),
        .ganhou       ( ganhou       ),
        .perdeu       ( perdeu       ),
        .timeout      ( timeout      ),
        .dbRodada     ( dbRodada     )
    );

    always #(clkPeriod / 2) clock = ~clock;

    // Round r shows and expects table entries 0..r and nothing beyond
    function automatic logic [playW-1:0] refPlay(input int round, input int pos);
        if (pos <= round) begin
            return playTable[pos];
        end
        return '0;
    endfunction

    // Next one-hot value, never equal to the given play
    function automatic logic [playW-1:0] nextOneHot(input logic [playW-1:0] play);
        return {play[playW-2:0], play[playW-1]};
    endfunction

    // LCG step with the better mixed upper half returned
    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {16'h0, seed[31:16]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Compare each newly lit play with the reference
    // Restart the count on a new round or while no game runs
    always @(posedge clock) begin
        ledsD   <= leds;
        rodadaD <= dbRodada;
        if (!arstN || pronto || dbRodada != rodadaD) begin
            shownCount <= 0;
        end else if (leds != '0 && ledsD == '0) begin
            checkValue("leds", 32'(leds), 32'(refPlay(int'(dbRodada), shownCount)));
            shownCount <= shownCount + 1;
        end
    end

    // Press, hold and release with random durations
    task automatic pressPlay(input logic [playW-1:0] play);
        int holdCycles;
        int releaseCycles;
        holdCycles = 2 + int'(nextRand() % 4);
        releaseCycles = 2 + int'(nextRand() % 4);
        @(posedge clock);
        chaves <= play;
        repeat (holdCycles) @(posedge clock);
        chaves <= '0;
        repeat (releaseCycles) @(posedge clock);
    endtask

    // All r+1 plays seen and then the dark gap before the FSM waits for moves
    task automatic waitShow(input int round);
        while (shownCount != round + 1) @(posedge clock);
        while (leds != '0) @(posedge clock);
        repeat (showCycles + 2) @(posedge clock);
    endtask

    task automatic startGame(input logic longLevel, input logic timedLevel);
        @(posedge clock);
        nivelJogadas <= longLevel;
        nivelTempo   <= timedLevel;
        iniciar      <= 1'b1;
        @(posedge clock);
        iniciar <= 1'b0;
        while (pronto) @(posedge clock);
        // Flags of the previous game cleared
        checkValue("ganhou", 32'(ganhou), 0);
        checkValue("perdeu", 32'(perdeu), 0);
        checkValue("timeout", 32'(timeout), 0);
    endtask

    // Repeat the reference plays with an optional wrong one or a pause in idleRound
    task automatic playGame(input int lastRound, input int wrongRound, input int wrongPos,
                            input int idleRound);
        logic [playW-1:0] play;
        for (int r = 0; r <= lastRound; r++) begin
            waitShow(r);
            checkValue("dbRodada", 32'(dbRodada), r);
            if (r == idleRound) begin
                return;
            end
            for (int p = 0; p <= r; p++) begin
                play = refPlay(r, p);
                if (r == wrongRound && p == wrongPos) begin
                    pressPlay(nextOneHot(play));
                    return;
                end
                pressPlay(play);
            end
        end
    endtask

    task automatic waitEnd(input logic expWon, input logic expTimeout, input int expRound);
        while (!(ganhou || perdeu)) @(posedge clock);
        checkValue("ganhou", 32'(ganhou), 32'(expWon));
        checkValue("perdeu", 32'(perdeu), 32'(!expWon));
        checkValue("timeout", 32'(timeout), 32'(expTimeout));
        checkValue("pronto", 32'(pronto), 1);
        checkValue("dbRodada", 32'(dbRodada), expRound);
    endtask

    initial begin
        int wrongRound;
        int wrongPos;
        clock        = 1'b0;
        arstN        = 1'b0;
        iniciar      = 1'b0;
        chaves       = '0;
        nivelJogadas = 1'b0;
        nivelTempo   = 1'b0;
        repeat (4) @(posedge clock);
        arstN <= 1'b1;
        @(posedge clock);
        checkValue("pronto", 32'(pronto), 1);
        checkValue("leds", 32'(leds), 0);

        // Full wins of both lengths without timer
        startGame(1'b0, 1'b0);
        playGame(roundsShort, -1, -1, -1);
        waitEnd(1'b1, 1'b0, roundsShort);
        startGame(1'b1, 1'b0);
        playGame(roundsLong, -1, -1, -1);
        waitEnd(1'b1, 1'b0, roundsLong);

        // Wrong play somewhere in a short game
        wrongRound = int'(nextRand() % (roundsShort + 1));
        wrongPos = int'(nextRand() % (wrongRound + 1));
        startGame(1'b0, 1'b0);
        playGame(roundsShort, wrongRound, wrongPos, -1);
        waitEnd(1'b0, 1'b0, wrongRound);

        // Player stops in round 1 with the timer on
        startGame(1'b0, 1'b1);
        playGame(roundsShort, -1, -1, 1);
        repeat (idleCycles) @(posedge clock);
        waitEnd(1'b0, 1'b1, 1);

        // Same pause with the timer off keeps the game waiting
        startGame(1'b0, 1'b0);
        playGame(roundsShort, -1, -1, 1);
        repeat (idleCycles) @(posedge clock);
        checkValue("perdeu", 32'(perdeu), 0);
        checkValue("ganhou", 32'(ganhou), 0);
        pressPlay(nextOneHot(refPlay(1, 0)));
        waitEnd(1'b0, 1'b0, 1);

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog at twice the worst case of all games
    initial begin
        #(numGames * gameCycles * clkPeriod * 2);
        $display("Watchdog expired, the game never reached its expected end");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
design/gamePkg.sv
design/seqRomPkg.sv
design/gameCtrlIf.sv
design/gameDatapath.sv
design/gameControl.sv
design/memoryGameTop.sv
verif/memoryGame_sva.sv
verif/memoryGameTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the memory game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module memoryGameTb -o memoryGameSim > build.log 2>&1 \
    && ./obj_dir/memoryGameSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -qx "Simulation PASSED" sim.log \
    && echo "Run result: pass" \
    || { echo "Run result: fail"; exit 1; }
